// File: src/pkt_buf_pkg.sv
// block geometry and block/footer types shared by the packet buffer RTL
package pkt_buf_pkg;

    localparam int BLOCK_BYTES   = 64;                       // one memory word
    localparam int PAYLOAD_BYTES = 62;
    localparam int BLOCK_BITS    = 8 * BLOCK_BYTES;
    localparam int FOOTER_BITS   = 16;
    localparam int PAYLOAD_BITS  = BLOCK_BITS - FOOTER_BITS;  // 496
    localparam int MAX_ADDR_W    = 14;                       // widest link the footer holds

    // sits in the low 16 bits of every block
    typedef struct packed {
        logic [MAX_ADDR_W-1:0] next_idx;  // link to the following block of the chain
        logic                  eop;       // last block of a packet
        logic                  rsvd;
    } footer_t;

    typedef struct packed {
        logic [PAYLOAD_BITS-1:0] payload;  // first byte received is the top byte
        footer_t                 footer;
    } block_t;

endpackage

// File: src/free_list.sv
// FIFO of free block indices, preloaded with every index after reset, feeds writer and reader
`timescale 1ns/100ps
module free_list #(
    parameter int ADDR_W = 5
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_req_i,
    output logic              alloc_gnt_o,
    output logic [ADDR_W-1:0] alloc_idx_o,
    input  logic              rel_valid_i,
    input  logic [ADDR_W-1:0] rel_idx_i,
    output logic [ADDR_W:0]   free_count_o
);
    localparam int NUM_BLOCKS = 2 ** ADDR_W;

    logic [ADDR_W-1:0] idx_mem [NUM_BLOCKS];
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W:0]   count;
    logic [ADDR_W:0]   init_cnt;   // msb set once every index is loaded
    logic              init_done;
    logic              push;
    logic              pop;
    logic [ADDR_W-1:0] push_idx;

    assign init_done    = init_cnt[ADDR_W];
    // pointers meet when empty or full, count msb tells the two apart
    assign alloc_gnt_o  = init_done && ((rd_ptr != wr_ptr) || count[ADDR_W]);
    assign alloc_idx_o  = idx_mem[rd_ptr];
    assign free_count_o = count;

    assign pop      = alloc_req_i && alloc_gnt_o;
    // loader owns the write side until init is done
    assign push     = init_done ? rel_valid_i : 1'b1;
    assign push_idx = init_done ? rel_idx_i : init_cnt[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (push) begin
            idx_mem[wr_ptr] <= push_idx;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            init_cnt <= '0;
        end else begin
            if (!init_done) begin
                init_cnt <= init_cnt + 1'b1;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps back to 0 after the load
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

// File: src/block_ram.sv
// single-port block store, a read owns the port and refuses any write in that cycle
`timescale 1ns/100ps
module block_ram
    import pkt_buf_pkg::*;
#(
    parameter int ADDR_W = 5
) (
    input  logic              clk,
    input  logic              rd_en_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output block_t            rd_data_o,
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  block_t            wr_data_i,
    output logic              wr_ready_o
);
    block_t mem [2**ADDR_W];

    // read wins, writer must hold its request
    assign wr_ready_o = !rd_en_i;

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];  // data valid next cycle
        end else if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

// File: src/memory_write_ctrl.sv
// packs the input byte stream into linked 64-byte blocks and announces each finished packet
`timescale 1ns/100ps
module memory_write_ctrl
    import pkt_buf_pkg::*;
#(
    parameter int ADDR_W = 5
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic [7:0]        data_i,
    input  logic              data_valid_i,
    input  logic              data_begin_i,
    input  logic              data_end_i,   // held on the last byte of a packet
    output logic              data_ready_o,

    output logic              fl_alloc_req_o,
    input  logic              fl_alloc_gnt_i,
    input  logic [ADDR_W-1:0] fl_alloc_block_idx_i,

    input  logic              mem_ready_i,
    output logic              mem_we_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output block_t            mem_wdata_o,

    output logic [ADDR_W-1:0] start_addr_o,
    output logic              pkt_done_o
);
    localparam int BEAT_W = $clog2(PAYLOAD_BYTES);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(PAYLOAD_BYTES - 1);

    typedef enum logic [1:0] {S_IDLE, S_PAYLOAD, S_WAIT, S_FOOTER} state_t;

    state_t state;
    state_t state_n;

    logic [PAYLOAD_BITS-1:0] payload_q;
    logic [BEAT_W-1:0]       beat_cnt;
    logic [ADDR_W-1:0]       cur_idx;     // block being filled
    logic [ADDR_W-1:0]       nxt_idx;     // spare, becomes the link
    logic [ADDR_W-1:0]       pkt_start;
    logic                    cur_valid;
    logic                    nxt_valid;
    logic                    eop_q;       // latched on the last payload beat
    footer_t                 footer;

    logic in_fire;
    logic start_beat;
    logic last_beat;
    logic footer_fire;
    logic first_beat;
    logic alloc_take;

    always_comb begin
        case (state)
            S_IDLE:    data_ready_o = cur_valid || fl_alloc_gnt_i;
            S_PAYLOAD: data_ready_o = 1'b1;
            S_WAIT:    data_ready_o = 1'b0;
            default:   data_ready_o = mem_ready_i;  // footer refused, hold the stream
        endcase
    end

    assign in_fire     = data_valid_i && data_ready_o;
    assign start_beat  = (state == S_IDLE) && in_fire && data_begin_i;
    assign last_beat   = (state == S_PAYLOAD) && in_fire && (beat_cnt == LAST_BEAT);
    assign footer_fire = (state == S_FOOTER) && mem_ready_i;
    // byte taken with the footer opens the next block or, after eop, the next packet
    assign first_beat  = footer_fire && in_fire && (!eop_q || data_begin_i);

    assign fl_alloc_req_o = (state == S_IDLE) ? (start_beat && !cur_valid)
                                              : !(cur_valid && nxt_valid);
    assign alloc_take     = fl_alloc_req_o && fl_alloc_gnt_i;

    // pulse on the cycle the eop block actually lands in memory
    assign pkt_done_o = mem_we_o && mem_ready_i && mem_wdata_o.footer.eop;

    always_comb begin
        footer          = '0;
        footer.next_idx = MAX_ADDR_W'(nxt_idx);
        footer.eop      = eop_q;
    end

    always_comb begin
        state_n = state;
        case (state)
            S_IDLE: begin
                if (start_beat) begin
                    state_n = S_PAYLOAD;
                end
            end
            S_PAYLOAD: begin
                if (last_beat) begin
                    state_n = (cur_valid && nxt_valid) ? S_FOOTER : S_WAIT;
                end
            end
            S_WAIT: begin
                if (cur_valid && nxt_valid) begin
                    state_n = S_FOOTER;
                end
            end
            default: begin
                if (footer_fire) begin
                    state_n = (eop_q && !first_beat) ? S_IDLE : S_PAYLOAD;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            beat_cnt  <= '0;
            cur_valid <= 1'b0;
            nxt_valid <= 1'b0;
            eop_q     <= 1'b0;
            mem_we_o  <= 1'b0;
        end else begin
            state    <= state_n;
            mem_we_o <= footer_fire || (mem_we_o && !mem_ready_i);  // retry a refused write
            if (alloc_take) begin
                if (!cur_valid) begin
                    cur_valid <= 1'b1;
                end else begin
                    nxt_valid <= 1'b1;
                end
            end
            if (footer_fire) begin
                nxt_valid <= 1'b0;  // spare moves to cur, also across packets
            end
            if (last_beat) begin
                eop_q <= data_end_i;
            end
            if (footer_fire) begin
                beat_cnt <= first_beat ? BEAT_W'(1) : '0;
            end else if (start_beat) begin
                beat_cnt <= BEAT_W'(1);
            end else if ((state == S_PAYLOAD) && in_fire) begin
                beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_take) begin
            if (!cur_valid) begin
                cur_idx <= fl_alloc_block_idx_i;
            end else begin
                nxt_idx <= fl_alloc_block_idx_i;
            end
        end
        if (start_beat) begin
            pkt_start <= cur_valid ? cur_idx : fl_alloc_block_idx_i;
        end else if (footer_fire && eop_q && first_beat) begin
            pkt_start <= nxt_idx;
        end
        if (footer_fire) begin
            cur_idx      <= nxt_idx;
            mem_addr_o   <= cur_idx;
            mem_wdata_o  <= {payload_q, footer};
            start_addr_o <= pkt_start;
        end
        if ((state == S_PAYLOAD && in_fire) || start_beat || first_beat) begin
            payload_q <= {payload_q[PAYLOAD_BITS-9:0], data_i};
        end
    end

endmodule

// File: src/packet_reader.sv
// walks finished block chains from their start block, streams the bytes and frees each block
`timescale 1ns/100ps
module packet_reader
    import pkt_buf_pkg::*;
#(
    parameter int ADDR_W      = 5,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_valid_i,
    input  logic [ADDR_W-1:0] start_idx_i,
    output logic              rd_en_o,
    output logic [ADDR_W-1:0] rd_addr_o,
    input  block_t            rd_data_i,
    output logic              rel_valid_o,
    output logic [ADDR_W-1:0] rel_idx_o,
    output logic [7:0]        out_data_o,
    output logic              out_valid_o,
    output logic              out_first_o,
    output logic              out_last_o
);
    localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
    localparam int BYTE_W = $clog2(PAYLOAD_BYTES);
    localparam logic [BYTE_W-1:0] LAST_BYTE = BYTE_W'(PAYLOAD_BYTES - 1);

    typedef enum logic [1:0] {R_IDLE, R_FETCH, R_LOAD, R_STREAM} state_t;

    state_t                  state;
    logic [ADDR_W-1:0]       start_q [QUEUE_DEPTH];
    logic [PTR_W-1:0]        q_rd_ptr;
    logic [PTR_W-1:0]        q_wr_ptr;
    logic [CNT_W-1:0]        q_cnt;
    logic                    q_push;
    logic                    q_pop;
    logic [ADDR_W-1:0]       blk_idx;   // block now on the output
    logic [ADDR_W-1:0]       link_idx;  // from its footer
    logic [PAYLOAD_BITS-1:0] shift_q;
    logic [BYTE_W-1:0]       byte_cnt;
    logic                    blk_eop;
    logic                    pkt_first;
    logic                    blk_done;

    assign q_push   = start_valid_i && (q_cnt != CNT_W'(QUEUE_DEPTH));
    assign q_pop    = (state == R_IDLE) && (q_cnt != '0);
    assign blk_done = (state == R_STREAM) && (byte_cnt == LAST_BYTE);

    // a new chain reads straight from the queue head
    assign rd_en_o   = q_pop || (state == R_FETCH);
    assign rd_addr_o = (state == R_IDLE) ? start_q[q_rd_ptr] : blk_idx;

    assign out_valid_o = (state == R_STREAM);
    assign out_data_o  = shift_q[PAYLOAD_BITS-1 -: 8];  // msb byte first
    assign out_last_o  = blk_done && blk_eop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= R_IDLE;
            q_rd_ptr    <= '0;
            q_wr_ptr    <= '0;
            q_cnt       <= '0;
            byte_cnt    <= '0;
            blk_eop     <= 1'b0;
            pkt_first   <= 1'b0;
            out_first_o <= 1'b0;
            rel_valid_o <= 1'b0;
        end else begin
            rel_valid_o <= blk_done;  // free the block once its last byte is out
            if (q_push) begin
                q_wr_ptr <= (q_wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
            end
            if (q_pop) begin
                q_rd_ptr <= (q_rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
            end
            case ({q_push, q_pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
            case (state)
                R_IDLE: begin
                    if (q_pop) begin
                        state     <= R_LOAD;
                        pkt_first <= 1'b1;
                    end
                end
                R_FETCH: state <= R_LOAD;
                R_LOAD: begin
                    state       <= R_STREAM;
                    byte_cnt    <= '0;
                    blk_eop     <= rd_data_i.footer.eop;
                    out_first_o <= pkt_first;  // only the head block of a chain
                    pkt_first   <= 1'b0;
                end
                default: begin
                    out_first_o <= 1'b0;
                    byte_cnt    <= byte_cnt + 1'b1;
                    if (blk_done) begin
                        state <= blk_eop ? R_IDLE : R_FETCH;  // follow the link
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) begin
            start_q[q_wr_ptr] <= start_idx_i;
        end
        if (q_pop) begin
            blk_idx <= start_q[q_rd_ptr];
        end
        if (state == R_LOAD) begin
            shift_q  <= rd_data_i.payload;
            link_idx <= rd_data_i.footer.next_idx[ADDR_W-1:0];
        end else if (state == R_STREAM) begin
            shift_q <= shift_q << 8;
        end
        if (blk_done) begin
            rel_idx_o <= blk_idx;
            blk_idx   <= link_idx;
        end
    end

endmodule

// File: src/packet_buffer_top.sv
// packet buffer top, ties free list, block memory, writer and reader together
`timescale 1ns/100ps
module packet_buffer_top
    import pkt_buf_pkg::*;
#(
    parameter int ADDR_W      = 5,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [7:0]      data_i,
    input  logic            data_valid_i,
    input  logic            data_begin_i,
    input  logic            data_end_i,
    output logic            data_ready_o,
    output logic [7:0]      out_data_o,
    output logic            out_valid_o,
    output logic            out_first_o,
    output logic            out_last_o,
    output logic [ADDR_W:0] free_count_o
);
    logic              alloc_req;
    logic              alloc_gnt;
    logic [ADDR_W-1:0] alloc_idx;
    logic              rel_valid;
    logic [ADDR_W-1:0] rel_idx;
    logic              wr_en;
    logic              wr_ready;
    logic [ADDR_W-1:0] wr_addr;
    block_t            wr_data;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    block_t            rd_data;
    logic              pkt_done;
    logic [ADDR_W-1:0] start_idx;

    free_list #(.ADDR_W(ADDR_W)) u_free_list (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_req_i  (alloc_req),
        .alloc_gnt_o  (alloc_gnt),
        .alloc_idx_o  (alloc_idx),
        .rel_valid_i  (rel_valid),
        .rel_idx_i    (rel_idx),
        .free_count_o (free_count_o)
    );

    block_ram #(.ADDR_W(ADDR_W)) u_block_ram (
        .clk        (clk),
        .rd_en_i    (rd_en),
        .rd_addr_i  (rd_addr),
        .rd_data_o  (rd_data),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .wr_ready_o (wr_ready)
    );

    memory_write_ctrl #(.ADDR_W(ADDR_W)) u_writer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .data_i               (data_i),
        .data_valid_i         (data_valid_i),
        .data_begin_i         (data_begin_i),
        .data_end_i           (data_end_i),
        .data_ready_o         (data_ready_o),
        .fl_alloc_req_o       (alloc_req),
        .fl_alloc_gnt_i       (alloc_gnt),
        .fl_alloc_block_idx_i (alloc_idx),
        .mem_ready_i          (wr_ready),
        .mem_we_o             (wr_en),
        .mem_addr_o           (wr_addr),
        .mem_wdata_o          (wr_data),
        .start_addr_o         (start_idx),
        .pkt_done_o           (pkt_done)
    );

    packet_reader #(
        .ADDR_W      (ADDR_W),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_reader (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_valid_i (pkt_done),
        .start_idx_i   (start_idx),
        .rd_en_o       (rd_en),
        .rd_addr_o     (rd_addr),
        .rd_data_i     (rd_data),
        .rel_valid_o   (rel_valid),
        .rel_idx_o     (rel_idx),
        .out_data_o    (out_data_o),
        .out_valid_o   (out_valid_o),
        .out_first_o   (out_first_o),
        .out_last_o    (out_last_o)
    );

endmodule

// File: sim/packet_buffer_props.sv
// concurrent checks on free list, memory port and output flags, bound into the buffer top
`timescale 1ns/100ps
module packet_buffer_props #(
    parameter int ADDR_W = 5
) (
    input logic              clk,
    input logic              rst_n,
    input logic              alloc_gnt,
    input logic              wr_en,
    input logic              wr_ready,
    input logic [ADDR_W-1:0] wr_addr,
    input logic              out_valid,
    input logic              out_first,
    input logic [ADDR_W:0]   free_count
);
    localparam int NUM_BLOCKS = 2 ** ADDR_W;

    no_grant_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_gnt |-> (free_count != '0))
        else $error("free list granted a block while empty");

    // a write refused by a read stays on the port until it lands
    refused_write_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en && !wr_ready) |=> (wr_en && $stable(wr_addr)))
        else $error("memory write dropped or changed after a read refused it");

    first_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_first |-> out_valid)
        else $error("out_first_o raised without out_valid_o");

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        free_count <= NUM_BLOCKS)
        else $error("free count exceeds the number of blocks");

endmodule

bind packet_buffer_top packet_buffer_props #(.ADDR_W(ADDR_W)) u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc_gnt  (alloc_gnt),
    .wr_en      (wr_en),
    .wr_ready   (wr_ready),
    .wr_addr    (wr_addr),
    .out_valid  (out_valid_o),
    .out_first  (out_first_o),
    .free_count (free_count_o)
);

// File: sim/tb_packet_buffer.sv
// self-checking testbench for the packet buffer, applies a stimulus table to the top level
`timescale 1ns/100ps
module tb_packet_buffer;

    localparam int ADDR_W      = 5;
    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_BLOCKS  = 2 ** ADDR_W;
    localparam int PAYLOAD     = 62;   // bytes per block
    localparam int NUM_ROWS    = 5;

    typedef struct packed {
        logic [7:0] data;
        logic       first;
        logic       last;
    } exp_beat_t;

    // b2b rows send packets of 1 up to blocks blocks without draining in between
    typedef struct {
        string      name;
        int         blocks;
        bit         rand_pat;  // else incrementing from seed
        logic [7:0] seed;
        int         gap;       // max idle cycles between bytes
        bit         b2b;
    } test_row_t;

    logic            clk;
    logic            rst_n;
    logic [7:0]      data_i;
    logic            data_valid_i;
    logic            data_begin_i;
    logic            data_end_i;
    logic            data_ready_o;
    logic [7:0]      out_data_o;
    logic            out_valid_o;
    logic            out_first_o;
    logic            out_last_o;
    logic [ADDR_W:0] free_count_o;

    test_row_t  tests [NUM_ROWS];
    exp_beat_t  sb [$];
    string      cur_test;
    int         err_cnt;
    int         out_cnt;
    int         tests_failed;
    logic [7:0] next_val;

    packet_buffer_top #(
        .ADDR_W      (ADDR_W),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_i       (data_i),
        .data_valid_i (data_valid_i),
        .data_begin_i (data_begin_i),
        .data_end_i   (data_end_i),
        .data_ready_o (data_ready_o),
        .out_data_o   (out_data_o),
        .out_valid_o  (out_valid_o),
        .out_first_o  (out_first_o),
        .out_last_o   (out_last_o),
        .free_count_o (free_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int row_bytes(input test_row_t row);
        if (row.b2b) begin
            return row.blocks * (row.blocks + 1) / 2 * PAYLOAD;
        end
        return row.blocks * PAYLOAD;
    endfunction

    task automatic watchdog();
        longint limit_cyc;
        limit_cyc = 200;  // init phase
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit_cyc += row_bytes(tests[i]) + 200;
        end
        repeat (limit_cyc * 4) @(posedge clk);
        $display("watchdog expired during test %s, run stopped", cur_test);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // holds the byte until the DUT takes it
    task automatic send_byte(input logic [7:0] val, input logic first, input logic last);
        logic taken;
        data_i       = val;
        data_valid_i = 1'b1;
        data_begin_i = first;
        data_end_i   = last;
        taken        = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = data_ready_o;  // stable mid cycle
            @(posedge clk);
            #1;
        end
        data_valid_i = 1'b0;
        data_begin_i = 1'b0;
        data_end_i   = 1'b0;
    endtask

    task automatic send_packet(input int blocks, input bit rand_pat, input int gap);
        int        n_bytes;
        int        idle;
        exp_beat_t beat;
        n_bytes = blocks * PAYLOAD;
        for (int k = 0; k < n_bytes; k++) begin
            beat.data  = rand_pat ? 8'($urandom) : next_val;
            beat.first = (k == 0);
            beat.last  = (k == n_bytes - 1);
            next_val   = next_val + 8'd1;
            sb.push_back(beat);
            send_byte(beat.data, beat.first, beat.last);
            idle = (gap > 0 && k != n_bytes - 1) ? $urandom_range(gap, 0) : 0;
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_cnt != errs_before) begin
            tests_failed++;
        end
        $display("test %-20s %s, %0d errors", name,
                 (err_cnt == errs_before) ? "pass" : "fail", err_cnt - errs_before);
    endtask

    task automatic check_init();
        int wait_cyc;
        int errs_before;
        errs_before = err_cnt;
        cur_test    = "init";
        wait_cyc    = 0;
        while (!data_ready_o && wait_cyc < 200) begin
            assert (!out_valid_o) else begin
                $display("output valid raised before any input was sent");
                err_cnt++;
            end
            @(posedge clk);
            #1;
            wait_cyc++;
        end
        assert (data_ready_o) else begin
            $display("data_ready_o never rose after reset");
            err_cnt++;
        end
        assert (free_count_o == NUM_BLOCKS) else begin
            $display("ERR %s free_count expected %0d actual %0d", cur_test, NUM_BLOCKS,
                     free_count_o);
            err_cnt++;
        end
        report(cur_test, errs_before);
    endtask

    task automatic run_row(input test_row_t row);
        int errs_before;
        errs_before = err_cnt;
        cur_test    = row.name;
        next_val    = row.seed;
        if (row.b2b) begin
            for (int p = 1; p <= row.blocks; p++) begin
                send_packet(p, row.rand_pat, row.gap);
            end
        end else begin
            send_packet(row.blocks, row.rand_pat, row.gap);
        end
        while (sb.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);  // let the last release land
        #1;
        // writer keeps one spare block, all others are back
        assert (free_count_o == NUM_BLOCKS - 1) else begin
            $display("ERR %s free_count expected %0d actual %0d", cur_test, NUM_BLOCKS - 1,
                     free_count_o);
            err_cnt++;
        end
        report(row.name, errs_before);
    endtask

    // scoreboard compare of every output byte
    always @(negedge clk) begin
        exp_beat_t exp;
        if (rst_n && out_valid_o) begin
            assert (sb.size() != 0) else begin
                $display("output byte 0x%02h in test %s arrived with nothing expected",
                         out_data_o, cur_test);
                err_cnt++;
            end
            if (sb.size() != 0) begin
                exp = sb.pop_front();
                assert (out_data_o == exp.data) else begin
                    $display("ERR %s byte %0d data expected 0x%02h actual 0x%02h",
                             cur_test, out_cnt, exp.data, out_data_o);
                    err_cnt++;
                end
                assert (out_first_o == exp.first) else begin
                    $display("ERR %s byte %0d first expected %0b actual %0b",
                             cur_test, out_cnt, exp.first, out_first_o);
                    err_cnt++;
                end
                assert (out_last_o == exp.last) else begin
                    $display("ERR %s byte %0d last expected %0b actual %0b",
                             cur_test, out_cnt, exp.last, out_last_o);
                    err_cnt++;
                end
                out_cnt++;
            end
        end
    end

    initial begin
        int seed_val;
        seed_val     = $urandom(32'h42f0);
        rst_n        = 1'b0;
        data_i       = '0;
        data_valid_i = 1'b0;
        data_begin_i = 1'b0;
        data_end_i   = 1'b0;
        err_cnt      = 0;
        out_cnt      = 0;
        tests_failed = 0;
        cur_test     = "reset";
        next_val     = '0;
        //          name                  blocks rand  seed   gap b2b
        tests[0] = '{"single_block",       1,     1'b0, 8'h00, 0,  1'b0};
        tests[1] = '{"four_block_random",  4,     1'b1, 8'h00, 0,  1'b0};
        tests[2] = '{"three_back_to_back", 3,     1'b0, 8'h40, 0,  1'b1};
        tests[3] = '{"random_gaps",        2,     1'b1, 8'h00, 3,  1'b0};
        tests[4] = '{"many_packets",       4,     1'b0, 8'h80, 1,  1'b1};
        fork
            watchdog();
        join_none
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_init();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(tests[i]);
        end
        $display("tests run %0d, failed %0d, errors %0d", NUM_ROWS + 1, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
src/pkt_buf_pkg.sv
src/free_list.sv
src/block_ram.sv
src/memory_write_ctrl.sv
src/packet_reader.sv
src/packet_buffer_top.sv
sim/packet_buffer_props.sv
sim/tb_packet_buffer.sv

// File: Bender.yml
package:
  name: packet_buffer

sources:
  - target: any(synthesis, simulation)
    files:
      - src/pkt_buf_pkg.sv
      - src/free_list.sv
      - src/block_ram.sv
      - src/memory_write_ctrl.sv
      - src/packet_reader.sv
      - src/packet_buffer_top.sv
  - target: simulation
    files:
      - sim/packet_buffer_props.sv
      - sim/tb_packet_buffer.sv
